//--- rs_pkg.sv
package rs_pkg;

	// ----------------------------------------
	// field parameters
	// ----------------------------------------

	// width of one GF(32) element in bits
	localparam int SYM_W = 5;

	// x^5 + x^2 + 1 with the x^5 term dropped, folded back in on every overflow
	localparam logic [SYM_W-1:0] FIELD_POLY = 5'b00101;

	// number of non-zero field elements, which is also the order of alpha
	localparam int FIELD_ORDER = (1 << SYM_W) - 1;

	// twelve check symbols, so up to six symbol errors are correctable
	localparam int MAX_SYN = 12;

	// ----------------------------------------
	// types
	// ----------------------------------------

	// one field element, bit k is the coefficient of alpha^k
	typedef logic [SYM_W-1:0] sym_t;

	// codeword length, legal values are 1 to 31
	typedef logic [4:0] len_t;

	// entry i holds the syndrome evaluated at alpha^(i+1)
	typedef sym_t [MAX_SYN-1:0] syn_vec_t;

	// final report of one codeword
	typedef struct packed {
		logic with_error;
		syn_vec_t syndromes;
	} rs_result_t;

	// ----------------------------------------
	// field arithmetic
	// ----------------------------------------

	// polynomial-basis product, one shift per bit of b
	function automatic sym_t gf_mul(sym_t a, sym_t b);
		sym_t prod;
		sym_t sh;
		prod = '0;
		sh = a;
		for (int i = 0; i < SYM_W; i++)
		begin
			if (b[i])
				prod = prod ^ sh;
			// multiply sh by alpha, reducing when the top bit falls out
			sh = {sh[SYM_W-2:0], 1'b0} ^ (sh[SYM_W-1] ? FIELD_POLY : sym_t'(0));
		end
		return prod;
	endfunction

	// alpha^p for any integer p, the exponent wraps every FIELD_ORDER steps
	function automatic sym_t gf_alpha_pow(int p);
		int e;
		sym_t r;
		e = p % FIELD_ORDER;
		if (e < 0)
			e = e + FIELD_ORDER;
		r = sym_t'(1);
		// fixed trip count keeps this usable in constant expressions
		for (int i = 0; i < FIELD_ORDER; i++)
		begin
			if (i < e)
				r = gf_mul(r, sym_t'(2));
		end
		return r;
	endfunction

endpackage

//--- rs_syn_cell.sv
`timescale 1ns/1ps

// one Horner accumulator, evaluating the received word at alpha^POWER
module rs_syn_cell #(
	parameter int POWER = 1
) (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic step,
	input rs_pkg::sym_t sym,
	output rs_pkg::sym_t acc
);

	import rs_pkg::*;

	// the multiplier is a fixed field constant, so gf_mul below
	// reduces to a handful of xor gates after synthesis
	localparam sym_t ALPHA_K = gf_alpha_pow(POWER);

	// next value of the accumulator for a later symbol
	sym_t horner;

	// acc * alpha^POWER + sym, addition in GF(2^m) is xor
	always_comb
	begin
		horner = gf_mul(acc, ALPHA_K) ^ sym;
	end

	// the first symbol overwrites whatever the previous codeword left
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			acc <= '0;
		end
		else if (load)
		begin
			acc <= sym;
		end
		else if (step)
		begin
			acc <= horner;
		end
		// with neither strobe the value holds, which keeps result stable
	end

endmodule

//--- rs_syn_bank.sv
`timescale 1ns/1ps

// row of syndrome accumulators plus the error-detected flag
module rs_syn_bank #(
	// must not exceed rs_pkg::MAX_SYN
	parameter int NUM_SYN = 12
) (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic step,
	input rs_pkg::sym_t sym,
	output rs_pkg::rs_result_t result
);

	import rs_pkg::*;

	// one accumulator output per syndrome index
	sym_t acc [NUM_SYN];

	// packed view handed to the result, unused entries stay zero
	syn_vec_t syn_vec;

	// ----------------------------------------
	// accumulator row
	// ----------------------------------------

	genvar gi;
	generate
		for (gi = 0; gi < NUM_SYN; gi++)
		begin : g_cell
			// syndrome gi is the received polynomial at alpha^(gi+1)
			rs_syn_cell #(
				.POWER(gi + 1)
			) u_cell (
				.clk(clk),
				.rst_n(rst_n),
				.load(load),
				.step(step),
				.sym(sym),
				.acc(acc[gi])
			);
		end
	endgenerate

	// ----------------------------------------
	// result packing
	// ----------------------------------------

	always_comb
	begin
		syn_vec = '0;
		for (int i = 0; i < NUM_SYN; i++)
		begin
			syn_vec[i] = acc[i];
		end
	end

	// a valid codeword has every syndrome zero,
	// so any set bit anywhere means the word is corrupted
	always_comb
	begin
		result.with_error = |syn_vec;
		result.syndromes = syn_vec;
	end

endmodule

//--- rs_syn_ctrl.sv
`timescale 1ns/1ps

// codeword framing, turns a plain symbol strobe into load, step and done
module rs_syn_ctrl (
	input logic clk,
	input logic rst_n,
	input logic sym_valid,
	input rs_pkg::len_t cw_len,
	output logic load,
	output logic step,
	output logic done
);

	import rs_pkg::*;

	// ----------------------------------------
	// state
	// ----------------------------------------

	// high between the first and the last symbol of a codeword
	logic busy;

	// length captured with the first symbol
	len_t len_q;

	// symbols accepted so far in the current codeword
	len_t cnt;

	// count after the symbol on the input is taken
	len_t cnt_nxt;

	// length to compare against, the live input while idle
	len_t len_cur;

	// the symbol on the input closes the codeword
	logic last;

	// ----------------------------------------
	// strobe decode
	// ----------------------------------------

	// the first symbol of a word is whichever one arrives while idle
	assign load = sym_valid & ~busy;
	assign step = sym_valid & busy;

	always_comb
	begin
		// an idle controller starts counting at one, the first symbol itself
		cnt_nxt = busy ? cnt + len_t'(1) : len_t'(1);
		len_cur = busy ? len_q : cw_len;
		// greater-or-equal also closes a word whose length reads zero
		// after a single symbol instead of running the counter around
		last = sym_valid && (cnt_nxt >= len_cur);
	end

	// ----------------------------------------
	// sequencing
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			len_q <= '0;
			cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			// one-cycle pulse in the cycle after the last symbol,
			// the accumulators settle at that same edge
			done <= last;

			if (load)
			begin
				len_q <= cw_len;
			end

			if (sym_valid)
			begin
				if (last)
				begin
					// dropping busy here lets the next word's first symbol
					// arrive while done is still high
					busy <= 1'b0;
					cnt <= '0;
				end
				else
				begin
					busy <= 1'b1;
					cnt <= cnt_nxt;
				end
			end
		end
	end

endmodule

//--- rs_syndrome_top.sv
`timescale 1ns/1ps

// syndrome front end of the GF(32) Reed-Solomon decoder
module rs_syndrome_top #(
	// number of syndromes evaluated, at most rs_pkg::MAX_SYN
	parameter int NUM_SYN = 12
) (
	input logic clk,
	input logic rst_n,
	input logic sym_valid,
	input rs_pkg::sym_t sym,
	input rs_pkg::len_t cw_len,
	output logic done,
	output rs_pkg::rs_result_t result
);

	import rs_pkg::*;

	// first symbol of a codeword
	logic load;

	// every later symbol
	logic step;

	// ----------------------------------------
	// framing
	// ----------------------------------------

	rs_syn_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.sym_valid(sym_valid),
		.cw_len(cw_len),
		.load(load),
		.step(step),
		.done(done)
	);

	// ----------------------------------------
	// syndrome evaluation
	// ----------------------------------------

	// symbols go straight in, the bank updates at the strobe edge
	rs_syn_bank #(
		.NUM_SYN(NUM_SYN)
	) u_bank (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.step(step),
		.sym(sym),
		.result(result)
	);

endmodule

//--- rs_syn_ctrl_asserts.sv
`timescale 1ns/1ps

// protocol checks on the codeword controller
module rs_syn_ctrl_asserts (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic step,
	input logic done,
	input rs_pkg::len_t cw_len
);

	// ----------------------------------------
	// properties
	// ----------------------------------------

	// done is a single-cycle pulse per codeword
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done stayed high for two consecutive cycles");

	// the word is already closed while done is high,
	// so a symbol in that cycle must start the next word
	a_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !step)
		else $error("symbol extended a codeword that had already finished");

	// a codeword starts only with a usable length
	a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		load |-> (cw_len != '0))
		else $error("codeword started with a zero length");

endmodule

// attach to every controller instance
bind rs_syn_ctrl rs_syn_ctrl_asserts u_ctrl_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.load(load),
	.step(step),
	.done(done),
	.cw_len(cw_len)
);

//--- tb_rs_syndrome.sv
`timescale 1ns/1ps

// testbench for the GF(32) syndrome front end
module tb_rs_syndrome;

	import rs_pkg::*;

	// cycles allowed between the last symbol and done
	localparam int TIMEOUT_CYCLES = 40;
	localparam int NUM_RANDOM = 50;

	logic clk = 1'b0;
	logic rst_n;
	logic sym_valid;
	sym_t sym;
	len_t cw_len;
	logic done;
	rs_result_t result;

	// random source state, advanced one bit at a time
	logic [15:0] lfsr;

	// symbols of the codeword being sent, highest degree first
	sym_t word_q[$];

	// the last checked result, which must hold while the DUT is idle
	rs_result_t last_exp;

	rs_syndrome_top #(
		.NUM_SYN(12)
	) uut (
		.clk(clk),
		.rst_n(rst_n),
		.sym_valid(sym_valid),
		.sym(sym),
		.cw_len(cw_len),
		.done(done),
		.result(result)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// ----------------------------------------
	// random numbers and reference model
	// ----------------------------------------

	// x^16 + x^14 + x^13 + x^11 + 1, the new bit enters at the bottom
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// draws n bits, one LFSR step per bit, first drawn bit ends up highest
	task automatic rand_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			val = {val[14:0], lfsr[0]};
		end
	endtask

	// full 9-bit carry-less product first, then reduce by x^5 + x^2 + 1
	function automatic sym_t field_mul(sym_t a, sym_t b);
		logic [8:0] p;
		p = '0;
		for (int i = 0; i < SYM_W; i++)
		begin
			if (b[i])
				p = p ^ ({4'b0000, a} << i);
		end
		for (int k = 8; k >= SYM_W; k--)
		begin
			if (p[k])
				p = p ^ (9'h025 << (k - SYM_W));
		end
		return p[4:0];
	endfunction

	// alpha is the element x, its order is 31
	function automatic sym_t alpha_power(int p);
		sym_t r;
		r = 5'd1;
		repeat (p % 31)
			r = field_mul(r, 5'd2);
		return r;
	endfunction

	// Horner evaluation of word_q at alpha^(i+1) for every syndrome index
	function automatic rs_result_t model_result();
		rs_result_t m;
		sym_t a;
		sym_t acc;
		m = '0;
		for (int i = 0; i < MAX_SYN; i++)
		begin
			a = alpha_power(i + 1);
			acc = '0;
			foreach (word_q[k])
				acc = field_mul(acc, a) ^ word_q[k];
			m.syndromes[i] = acc;
		end
		m.with_error = |m.syndromes;
		return m;
	endfunction

	// ----------------------------------------
	// checking and driving
	// ----------------------------------------

	task automatic check_val(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		if (act_v !== exp_v)
		begin
			$display("[ERROR] %s expected %0h actual %0h", name, exp_v, act_v);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_result(input string name, input rs_result_t exp);
		for (int i = 0; i < MAX_SYN; i++)
			check_val($sformatf("%s syndrome %0d", name, i),
				64'(exp.syndromes[i]), 64'(result.syndromes[i]));
		check_val({name, " with_error"}, 64'(exp.with_error), 64'(result.with_error));
	endtask

	// inputs change 1 ns after the rising edge, outputs are settled by then
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	// idle cycles, done stays low and the previous result must hold
	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			sym_valid = 1'b0;
			tick();
			check_val("idle done", 64'd0, 64'(done));
			check_result("idle hold", last_exp);
		end
	endtask

	// sends word_q, then waits for done and compares with exp
	// the caller chains the next word by calling again without idle cycles
	task automatic send_word(input string name, input rs_result_t exp, input logic gaps);
		int n;
		int waited;
		logic [15:0] r;
		n = word_q.size();
		for (int k = 0; k < n; k++)
		begin
			if (gaps && k > 0)
			begin
				rand_bits(2, r);
				for (int g = 0; g < int'(r[1:0]); g++)
				begin
					sym_valid = 1'b0;
					tick();
					check_val({name, " done in gap"}, 64'd0, 64'(done));
				end
			end
			sym_valid = 1'b1;
			sym = word_q[k];
			if (k == 0)
			begin
				cw_len = len_t'(n);
			end
			else
			begin
				// length is only sampled with the first symbol, so junk here
				rand_bits(5, r);
				cw_len = len_t'(r[4:0]);
			end
			tick();
			if (k < n - 1)
				check_val({name, " early done"}, 64'd0, 64'(done));
		end
		sym_valid = 1'b0;
		waited = 0;
		while (done !== 1'b1)
		begin
			if (waited >= TIMEOUT_CYCLES)
			begin
				$display("timeout: no done pulse within %0d cycles for %s",
					TIMEOUT_CYCLES, name);
				$display("TEST FAILED");
				$fatal(1, "timeout");
			end
			else
			begin
				tick();
				waited++;
			end
		end
		// done belongs to the cycle right after the last symbol
		check_val({name, " done latency"}, 64'd0, 64'(waited));
		check_result(name, exp);
		last_exp = exp;
	endtask

	// ----------------------------------------
	// scenarios
	// ----------------------------------------

	initial
	begin : stimulus
		rs_result_t exp;
		logic [15:0] r;
		len_t len;
		int gap;
		int j;
		sym_t e;

		lfsr = 16'd44;
		rst_n = 1'b0;
		sym_valid = 1'b0;
		sym = '0;
		cw_len = '0;
		last_exp = '0;
		repeat (4)
			tick();
		rst_n = 1'b1;

		// reset state, done low and every syndrome zero
		idle_cycles(6);

		// random words, gap 0 starts a word in the previous done cycle
		for (int w = 0; w < NUM_RANDOM; w++)
		begin
			rand_bits(5, r);
			len = len_t'(r[4:0]);
			if (len == 0)
				len = 1;
			rand_bits(2, r);
			gap = int'(r[1:0]);
			// a chained one-symbol word would give two done cycles in a row
			if (len == 1 && gap == 0)
				gap = 1;
			idle_cycles(gap);
			word_q.delete();
			for (int k = 0; k < int'(len); k++)
			begin
				rand_bits(5, r);
				word_q.push_back(sym_t'(r[4:0]));
			end
			send_word($sformatf("random word %0d", w), model_result(), 1'b1);
		end

		// all-zero word of full length is a valid codeword
		idle_cycles(2);
		word_q.delete();
		repeat (31)
			word_q.push_back(5'd0);
		exp = '0;
		send_word("zero word", exp, 1'b1);

		// single error e at degree j, syndrome i is e * alpha^((i+1)j)
		for (int t = 0; t < 4; t++)
		begin
			idle_cycles(1);
			rand_bits(5, r);
			e = sym_t'(r[4:0]);
			if (e == 0)
				e = 5'd1;
			rand_bits(5, r);
			j = int'(r[4:0]) % 31;
			word_q.delete();
			for (int k = 0; k < 31; k++)
				word_q.push_back((k == 30 - j) ? e : 5'd0);
			exp = '0;
			for (int i = 0; i < MAX_SYN; i++)
				exp.syndromes[i] = field_mul(e, alpha_power((i + 1) * j));
			exp.with_error = 1'b1;
			send_word($sformatf("single error %0d", t), exp, 1'b0);
		end

		// three words back to back, each result checked in its done cycle
		idle_cycles(2);
		for (int t = 0; t < 3; t++)
		begin
			word_q.delete();
			for (int k = 0; k < 9 + 3 * t; k++)
			begin
				rand_bits(5, r);
				word_q.push_back(sym_t'(r[4:0]));
			end
			send_word($sformatf("back to back %0d", t), model_result(), 1'b0);
		end
		idle_cycles(3);

		// one-symbol words, every syndrome equals the symbol
		for (int t = 0; t < 5; t++)
		begin
			idle_cycles(1);
			rand_bits(5, r);
			e = sym_t'(r[4:0]);
			word_q.delete();
			word_q.push_back(e);
			exp = '0;
			for (int i = 0; i < MAX_SYN; i++)
				exp.syndromes[i] = e;
			exp.with_error = (e != 0);
			send_word($sformatf("length one %0d", t), exp, 1'b0);
		end
		idle_cycles(2);

		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- sim.f
rs_pkg.sv
rs_syn_cell.sv
rs_syn_bank.sv
rs_syn_ctrl.sv
rs_syndrome_top.sv
rs_syn_ctrl_asserts.sv
tb_rs_syndrome.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the syndrome testbench with Verilator and runs it
# exit status is non-zero when the build fails or the run reports failure

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_rs_syndrome
BUILD_LOG=build.log
SIM_LOG=sim.log
EXE=obj_dir/sim_${TOP}

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator was not found on the PATH"
	exit 1
fi

# compile, with the bound assertions enabled
verilator --binary --timing --assert -f sim.f --top-module "${TOP}" \
	-o "sim_${TOP}" > "${BUILD_LOG}" 2>&1
build_status=$?
if [ ${build_status} -ne 0 ]; then
	cat "${BUILD_LOG}"
	echo "build failed with status ${build_status}"
	exit 1
fi

# run
"./${EXE}" > "${SIM_LOG}" 2>&1
run_status=$?
cat "${SIM_LOG}"

if grep -q "TEST FAILED" "${SIM_LOG}"; then
	echo "simulation reported a failure, see ${SIM_LOG}"
	exit 1
fi
if [ ${run_status} -ne 0 ]; then
	echo "simulator exited with status ${run_status}"
	exit 1
fi

echo "simulation finished without failures"
exit 0
